// File: verilog.f
+incdir+.
core_pkg.sv
fetch_unit.sv
instr_decode.sv
issue_window.sv
reg_file.sv
alu_unit.sv
out_port_unit.sv
cpu_core.sv
cpu_core_props.sv
cpu_core_tb.sv

// File: Makefile
SIM := obj_dir/Vcpu_core_tb
SRCS := $(filter-out +%,$(shell cat verilog.f)) core_params.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module cpu_core_tb -f verilog.f

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -Fqx '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: cpu_core_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module cpu_core_tb;

	localparam logic [5:0] fn_list [6] = '{`CORE_FN_ADD, `CORE_FN_SUB, `CORE_FN_AND,
		`CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_SLL};

	logic clk;
	logic rstn;
	logic [`CORE_PCW-2:0] imem_addr;
	logic [2*`CORE_XLEN-1:0] imem_rdata;
	logic [7:0] out_data;
	logic out_vld;
	logic out_rdy;
	logic [2*`CORE_XLEN-1:0] imem [2**(`CORE_PCW-1)];
	logic [31:0] prog [$];
	logic [7:0] exp_q [$];
	int seed = 84;
	int errors = 0;
	int nbytes = 0;
	int rdy_left = 0;
	logic held;
	logic [7:0] held_data;

	cpu_core dut_i (
		.clk(clk), .rstn(rstn), .o_i_addr(imem_addr), .i_i_rdata(imem_rdata),
		.o_out_data(out_data), .o_out_vld(out_vld), .i_out_rdy(out_rdy)
	);

	always #20 clk = ~clk;

	// synchronous read, data one cycle after the address
	always @(posedge clk) begin
		imem_rdata <= imem[imem_addr];
	end

	// ready level held for random stretches of 1 to 30 cycles
	always @(posedge clk) begin
		if (rdy_left == 0) begin
			out_rdy <= 1'($random(seed));
			rdy_left <= 1 + int'($unsigned($random(seed)) % 30);
		end else begin
			rdy_left <= rdy_left - 1;
		end
	end

	function automatic logic [31:0] enc_reg(logic [5:0] fn, logic [4:0] dd, logic [4:0] ds,
		logic [4:0] dt, logic [4:0] sh);
		return {`CORE_OP_REG, dd, ds, dt, sh, fn};
	endfunction

	function automatic logic [31:0] enc_imm(logic [5:0] op, logic [4:0] dd, logic [4:0] ds,
		logic [15:0] imm);
		return {op, dd, ds, imm};
	endfunction

	task automatic load_const(logic [4:0] rd, logic [31:0] v);
		prog.push_back(enc_imm(`CORE_OP_LUI, rd, 5'd0, v[31:16]));
		prog.push_back(enc_imm(`CORE_OP_ORI, rd, rd, v[15:0]));
	endtask

	// in-order interpreter, one expected byte per OUT
	function automatic void exec_program();
		logic [31:0] regs [`CORE_NREG];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] r;
		logic wr;
		foreach (regs[k]) begin
			regs[k] = '0;
		end
		foreach (prog[i]) begin
			w = prog[i];
			a = regs[w[20:16]];
			r = '0;
			wr = 1'b1;
			case (w[31:26])
				`CORE_OP_REG: begin
					case (w[5:0])
						`CORE_FN_ADD: r = a + regs[w[15:11]];
						`CORE_FN_SUB: r = a - regs[w[15:11]];
						`CORE_FN_AND: r = a & regs[w[15:11]];
						`CORE_FN_OR: r = a | regs[w[15:11]];
						`CORE_FN_XOR: r = a ^ regs[w[15:11]];
						`CORE_FN_SLL: r = a << w[10:6];
						default: wr = 1'b0;
					endcase
				end
				`CORE_OP_ADDI: r = a + {{16{w[15]}}, w[15:0]};
				`CORE_OP_ORI: r = a | {16'h0000, w[15:0]};
				`CORE_OP_LUI: r = {w[15:0], 16'h0000};
				`CORE_OP_OUT: begin
					exp_q.push_back(a[7:0]);
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && w[25:21] != 5'd0) begin
				regs[w[25:21]] = r;
			end
		end
	endfunction

	task automatic gen_program();
		logic [31:0] v;
		logic [4:0] d;
		logic [4:0] s;
		logic [4:0] t;
		int k;
		// each register function on fresh constants
		for (int i = 0; i < 6; i++) begin
			load_const(5'd1, $random(seed));
			load_const(5'd2, $random(seed));
			prog.push_back(enc_reg(fn_list[3'(i)], 5'd3, 5'd1, 5'd2, 5'($random(seed))));
			prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'd3, 16'h0000));
		end
		// immediates with the top bit set
		for (int i = 0; i < 4; i++) begin
			v = $random(seed);
			prog.push_back(enc_imm(`CORE_OP_ADDI, 5'd4, 5'd0, v[15:0] | 16'h8000));
			prog.push_back(enc_imm(`CORE_OP_ORI, 5'd5, 5'd4, v[31:16] | 16'h8000));
			prog.push_back(enc_imm(`CORE_OP_LUI, 5'd6, 5'd0, v[15:0]));
			prog.push_back(enc_reg(`CORE_FN_ADD, 5'd7, 5'd6, 5'd5, 5'd0));
			prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'd4, 16'h0000));
			prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'd5, 16'h0000));
			prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'd7, 16'h0000));
		end
		// back-to-back chain, each op reads the previous result
		load_const(5'd8, $random(seed));
		for (int i = 0; i < 8; i++) begin
			prog.push_back(enc_imm(`CORE_OP_ADDI, 5'(9 + i), 5'(8 + i), 16'($random(seed))));
			prog.push_back(enc_reg(`CORE_FN_XOR, 5'(9 + i), 5'(9 + i), 5'(8 + i), 5'd0));
			prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'(9 + i), 16'h0000));
		end
		// r0 keeps zero
		prog.push_back(enc_imm(`CORE_OP_LUI, 5'd0, 5'd0, 16'h1234));
		prog.push_back(enc_imm(`CORE_OP_ADDI, 5'd0, 5'd0, 16'h005a));
		prog.push_back(enc_reg(`CORE_FN_OR, 5'd0, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, 5'd0, 16'h0000));
		// random tail over r0..r7
		for (int r = 1; r < 8; r++) begin
			load_const(5'(r), $random(seed));
		end
		for (int i = 0; i < 300; i++) begin
			v = $random(seed);
			k = int'(v[5:3]) % 6;
			d = {2'b00, v[8:6]};
			s = {2'b00, v[11:9]};
			t = {2'b00, v[14:12]};
			case (v[2:0])
				3'd0, 3'd1, 3'd2: prog.push_back(enc_reg(fn_list[3'(k)], d, s, t, v[19:15]));
				3'd3: prog.push_back(enc_imm(`CORE_OP_ADDI, d, s, v[31:16]));
				3'd4: prog.push_back(enc_imm(`CORE_OP_ORI, d, s, v[31:16]));
				3'd5: prog.push_back(enc_imm(`CORE_OP_LUI, d, 5'd0, v[31:16]));
				3'd6: prog.push_back(enc_imm(`CORE_OP_OUT, 5'd0, s, 16'h0000));
				default: prog.push_back(32'h0000_0000);
			endcase
		end
	endtask

	task automatic watchdog(int cycles);
		repeat (cycles) @(posedge clk);
		$display("timeout after %0d cycles, %0d bytes never arrived", cycles, exp_q.size());
		$display("*** FAILED ***");
		$finish;
	endtask

	// handshake is settled by the falling edge
	always @(negedge clk) begin
		if (!rstn) begin
			held = 1'b0;
		end else begin
			if (held && out_data !== held_data) begin
				$display("mismatch at %0t: o_out_data changed while held, was 0x%02h now 0x%02h",
					$time, held_data, out_data);
				errors++;
			end
			if (out_vld && out_rdy) begin
				if (exp_q.size() == 0) begin
					$display("extra byte 0x%02h on the output port at %0t", out_data, $time);
					errors++;
				end else begin
					if (out_data !== exp_q[0]) begin
						$display("mismatch at %0t: o_out_data got 0x%02h expected 0x%02h",
							$time, out_data, exp_q[0]);
						errors++;
					end
					void'(exp_q.pop_front());
					nbytes++;
				end
			end
			held = out_vld && !out_rdy;
			held_data = out_data;
		end
	end

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		out_rdy = 1'b0;
		imem_rdata = '0;
		held = 1'b0;
		held_data = '0;
		for (int a = 0; a < 2**(`CORE_PCW-1); a++) begin
			imem[13'(a)] = '0;
		end
		gen_program();
		// older instruction in the upper word
		foreach (prog[i]) begin
			if (i % 2 == 0) begin
				imem[13'(i / 2)][2*`CORE_XLEN-1:`CORE_XLEN] = prog[i];
			end else begin
				imem[13'(i / 2)][`CORE_XLEN-1:0] = prog[i];
			end
		end
		exec_program();
		fork
			watchdog(40 * prog.size() + 200);
		join_none
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		if (out_vld !== 1'b0) begin
			$display("o_out_vld is not low in the first cycle after reset");
			errors++;
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// room for a stray byte to show up
		repeat (40) @(posedge clk);
		$display("checked %0d bytes, %0d errors", nbytes, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: cpu_core_props.sv
`timescale 1ns/1ps

module cpu_core_props (
	input logic clk,
	input logic rstn,
	input logic [7:0] i_out_data,
	input logic i_out_vld,
	input logic i_out_rdy,
	input core_pkg::dec_op_t i_alu_op,
	input core_pkg::dec_op_t i_out_op
);

	// a waiting byte stays put
	assert property (@(posedge clk) disable iff (!rstn)
		i_out_vld && !i_out_rdy |=> $stable(i_out_data))
		else $error("o_out_data changed while waiting for ready");

	assert property (@(posedge clk) !rstn |=> !i_out_vld)
		else $error("o_out_vld high in the cycle after reset");

	// one window entry feeds one unit
	assert property (@(posedge clk) disable iff (!rstn)
		i_alu_op.valid && i_out_op.valid |-> i_alu_op.ope != i_out_op.ope)
		else $error("ALU and OUT issue selected the same window entry");

endmodule

bind cpu_core cpu_core_props props_i (
	.clk(clk), .rstn(rstn), .i_out_data(o_out_data), .i_out_vld(o_out_vld),
	.i_out_rdy(i_out_rdy), .i_alu_op(alu_op), .i_out_op(out_op)
);

// File: cpu_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module cpu_core (
	input logic clk,
	input logic rstn,
	output logic [`CORE_PCW-2:0] o_i_addr,
	input logic [2*`CORE_XLEN-1:0] i_i_rdata,
	output logic [7:0] o_out_data,
	output logic o_out_vld,
	input logic i_out_rdy
);

	core_pkg::instr_u word0;
	core_pkg::instr_u word1;
	logic [1:0] word_vld;
	core_pkg::dec_op_t dec_op0;
	core_pkg::dec_op_t dec_op1;
	core_pkg::dec_op_t win_op0;
	core_pkg::dec_op_t win_op1;
	logic stall;
	core_pkg::dec_op_t alu_op;
	core_pkg::dec_op_t out_op;
	logic [`CORE_XLEN-1:0] alu_ds_val;
	logic [`CORE_XLEN-1:0] alu_dt_val;
	logic [`CORE_XLEN-1:0] out_ds_val;
	logic [3:0][`CORE_RADDR-1:0] raddr;
	logic [3:0][`CORE_XLEN-1:0] rdata;
	core_pkg::wb_t wb;
	logic out_busy;

	fetch_unit fetch_i (
		.clk(clk), .rstn(rstn), .i_rdata(i_i_rdata), .i_stall(stall),
		.o_addr(o_i_addr), .o_word0(word0), .o_word1(word1), .o_word_vld(word_vld)
	);

	instr_decode dec0_i (.i_word(word0), .o_op(dec_op0));
	instr_decode dec1_i (.i_word(word1), .o_op(dec_op1));

	// slots without returned data carry no operation
	assign win_op0 = word_vld[0] ? dec_op0 : '0;
	assign win_op1 = word_vld[1] ? dec_op1 : '0;

	issue_window win_i (
		.clk(clk), .rstn(rstn), .i_op0(win_op0), .i_op1(win_op1),
		.i_out_busy(out_busy), .i_wb(wb), .i_rdata(rdata), .o_stall(stall),
		.o_alu_op(alu_op), .o_out_op(out_op), .o_alu_ds_val(alu_ds_val),
		.o_alu_dt_val(alu_dt_val), .o_out_ds_val(out_ds_val), .o_raddr(raddr)
	);

	reg_file rf_i (.clk(clk), .rstn(rstn), .i_wb(wb), .i_raddr(raddr), .o_rdata(rdata));

	alu_unit alu_i (
		.clk(clk), .rstn(rstn), .i_op(alu_op), .i_ds_val(alu_ds_val),
		.i_dt_val(alu_dt_val), .o_wb(wb)
	);

	out_port_unit out_i (
		.clk(clk), .rstn(rstn), .i_op(out_op), .i_ds_val(out_ds_val), .i_rdy(i_out_rdy),
		.o_data(o_out_data), .o_vld(o_out_vld), .o_busy(out_busy)
	);

endmodule

// File: out_port_unit.sv
`timescale 1ns/1ps
`include "core_params.svh"

module out_port_unit (
	input logic clk,
	input logic rstn,
	input core_pkg::dec_op_t i_op,
	input logic [`CORE_XLEN-1:0] i_ds_val,
	input logic i_rdy,
	output logic [7:0] o_data,
	output logic o_vld,
	output logic o_busy
);

	logic load;

	assign load = i_op.valid && i_op.unit == core_pkg::unit_out;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_vld <= 1'b0;
		end else if (load) begin
			o_vld <= 1'b1;
		end else if (i_rdy) begin
			o_vld <= 1'b0;
		end
	end

	// byte held until it transfers
	always_ff @(posedge clk) begin
		if (load) begin
			o_data <= i_ds_val[7:0];
		end
	end

	// a byte leaving this cycle frees the port for the next one
	assign o_busy = o_vld && !i_rdy;

endmodule

// File: alu_unit.sv
`timescale 1ns/1ps
`include "core_params.svh"

module alu_unit (
	input logic clk,
	input logic rstn,
	input core_pkg::dec_op_t i_op,
	input logic [`CORE_XLEN-1:0] i_ds_val,
	input logic [`CORE_XLEN-1:0] i_dt_val,
	output core_pkg::wb_t o_wb
);

	logic [`CORE_XLEN-1:0] result;
	logic en_q;
	logic [`CORE_RADDR-1:0] addr_q;
	logic [`CORE_XLEN-1:0] data_q;

	always_comb begin
		case (i_op.ope)
			`CORE_OP_REG: begin
				case (i_op.fn)
					`CORE_FN_ADD: result = i_ds_val + i_dt_val;
					`CORE_FN_SUB: result = i_ds_val - i_dt_val;
					`CORE_FN_AND: result = i_ds_val & i_dt_val;
					`CORE_FN_OR: result = i_ds_val | i_dt_val;
					`CORE_FN_XOR: result = i_ds_val ^ i_dt_val;
					// shift amount from the instruction field
					`CORE_FN_SLL: result = i_ds_val << i_op.shamt;
					default: result = '0;
				endcase
			end
			`CORE_OP_ADDI: result = i_ds_val + i_op.imm;
			`CORE_OP_ORI: result = i_ds_val | i_op.imm;
			`CORE_OP_LUI: result = i_op.imm;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			en_q <= 1'b0;
		end else begin
			en_q <= i_op.valid && i_op.writes_dd;
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= i_op.dd;
		data_q <= result;
	end

	assign o_wb = '{en: en_q, addr: addr_q, data: data_q};

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
	input logic clk,
	input logic rstn,
	input core_pkg::wb_t i_wb,
	input logic [3:0][`CORE_RADDR-1:0] i_raddr,
	output logic [3:0][`CORE_XLEN-1:0] o_rdata
);

	logic [`CORE_XLEN-1:0] mem [`CORE_NREG];

	always_ff @(posedge clk) begin
		if (rstn && i_wb.en && i_wb.addr != '0) begin
			mem[i_wb.addr] <= i_wb.data;
		end
	end

	// r0 reads as zero
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			o_rdata[p] = (i_raddr[p] == '0) ? '0 : mem[i_raddr[p]];
		end
	end

endmodule

// File: issue_window.sv
`timescale 1ns/1ps
`include "core_params.svh"

module issue_window (
	input logic clk,
	input logic rstn,
	input core_pkg::dec_op_t i_op0,
	input core_pkg::dec_op_t i_op1,
	input logic i_out_busy,
	input core_pkg::wb_t i_wb,
	input logic [3:0][`CORE_XLEN-1:0] i_rdata,
	output logic o_stall,
	output core_pkg::dec_op_t o_alu_op,
	output core_pkg::dec_op_t o_out_op,
	output logic [`CORE_XLEN-1:0] o_alu_ds_val,
	output logic [`CORE_XLEN-1:0] o_alu_dt_val,
	output logic [`CORE_XLEN-1:0] o_out_ds_val,
	output logic [3:0][`CORE_RADDR-1:0] o_raddr
);

	core_pkg::dec_op_t win [`CORE_WIN];
	core_pkg::dec_op_t win_nxt [`CORE_WIN];
	logic [`CORE_NREG-1:0] board;
	logic [`CORE_NREG-1:0] board_set;
	logic [`CORE_NREG-1:0] board_clr;
	logic iss0;
	logic iss1;
	logic e1_raw;
	logic [1:0] n_valid;
	logic [1:0] n_iss;
	logic [1:0] n_rem;

	function automatic logic pending(core_pkg::dec_op_t op, logic [`CORE_NREG-1:0] b);
		pending = b[op.ds] || (op.uses_dt && b[op.dt]) || (op.writes_dd && b[op.dd]);
	endfunction

	function automatic logic unit_free(core_pkg::dec_op_t op, logic out_busy);
		unit_free = (op.unit == core_pkg::unit_alu) ||
			(op.unit == core_pkg::unit_out && !out_busy);
	endfunction

	// entries 0 and 1 are the only issue candidates
	assign o_raddr[0] = win[0].ds;
	assign o_raddr[1] = win[0].dt;
	assign o_raddr[2] = win[1].ds;
	assign o_raddr[3] = win[1].dt;

	// entry 1 must not read what entry 0 is about to write
	assign e1_raw = win[0].writes_dd &&
		(win[1].ds == win[0].dd || (win[1].uses_dt && win[1].dt == win[0].dd));

	assign iss0 = win[0].valid && !pending(win[0], board) && unit_free(win[0], i_out_busy);
	assign iss1 = iss0 && win[1].valid && win[1].unit != win[0].unit && !e1_raw &&
		!pending(win[1], board) && unit_free(win[1], i_out_busy);

	assign n_valid = 2'(win[0].valid) + 2'(win[1].valid) + 2'(win[2].valid);
	assign n_iss = 2'(iss0) + 2'(iss1);
	assign n_rem = n_valid - n_iss;
	assign o_stall = (n_rem >= 2'd2);

	always_comb begin
		o_alu_op = '0;
		o_out_op = '0;
		o_alu_ds_val = '0;
		o_alu_dt_val = '0;
		o_out_ds_val = '0;
		if (iss0) begin
			if (win[0].unit == core_pkg::unit_alu) begin
				o_alu_op = win[0];
				o_alu_ds_val = i_rdata[0];
				o_alu_dt_val = i_rdata[1];
			end else begin
				o_out_op = win[0];
				o_out_ds_val = i_rdata[0];
			end
		end
		if (iss1) begin
			if (win[1].unit == core_pkg::unit_alu) begin
				o_alu_op = win[1];
				o_alu_ds_val = i_rdata[2];
				o_alu_dt_val = i_rdata[3];
			end else begin
				o_out_op = win[1];
				o_out_ds_val = i_rdata[2];
			end
		end
	end

	// compact survivors to the front, then append new ops in order
	always_comb begin
		logic [2:0] cnt;
		cnt = '0;
		for (int i = 0; i < `CORE_WIN; i++) begin
			win_nxt[i] = '0;
		end
		for (int i = 0; i < `CORE_WIN; i++) begin
			if (i >= int'(n_iss) && win[i].valid) begin
				win_nxt[cnt[1:0]] = win[i];
				cnt = cnt + 3'd1;
			end
		end
		if (!o_stall) begin
			if (i_op0.valid && cnt < `CORE_WIN) begin
				win_nxt[cnt[1:0]] = i_op0;
				cnt = cnt + 3'd1;
			end
			if (i_op1.valid && cnt < `CORE_WIN) begin
				win_nxt[cnt[1:0]] = i_op1;
			end
		end
	end

	assign board_set = (o_alu_op.valid && o_alu_op.writes_dd) ?
		(`CORE_NREG'(1) << o_alu_op.dd) : '0;
	assign board_clr = i_wb.en ? (`CORE_NREG'(1) << i_wb.addr) : '0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `CORE_WIN; i++) begin
				win[i] <= '0;
			end
			board <= '0;
		end else begin
			win <= win_nxt;
			// a new issue wins over a same-cycle writeback
			board <= (board & ~board_clr) | board_set;
		end
	end

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps
`include "core_params.svh"

module instr_decode (
	input core_pkg::instr_u i_word,
	output core_pkg::dec_op_t o_op
);

	logic [15:0] imm;

	assign imm = i_word.imm_form.imm;

	always_comb begin
		o_op = '0;
		case (i_word.reg_form.ope)
			`CORE_OP_REG: begin
				o_op.valid = 1'b1;
				o_op.unit = core_pkg::unit_alu;
				o_op.ope = i_word.reg_form.ope;
				o_op.fn = i_word.reg_form.fn;
				o_op.ds = i_word.reg_form.ds;
				o_op.dt = i_word.reg_form.dt;
				o_op.uses_dt = 1'b1;
				o_op.dd = i_word.reg_form.dd;
				o_op.shamt = i_word.reg_form.shamt;
			end
			`CORE_OP_ADDI, `CORE_OP_ORI, `CORE_OP_LUI: begin
				o_op.valid = 1'b1;
				o_op.unit = core_pkg::unit_alu;
				o_op.ope = i_word.imm_form.ope;
				o_op.ds = i_word.imm_form.ds;
				o_op.dd = i_word.imm_form.dd;
				if (i_word.imm_form.ope == `CORE_OP_ADDI) begin
					o_op.imm = {{(`CORE_XLEN-16){imm[15]}}, imm};
				end else if (i_word.imm_form.ope == `CORE_OP_ORI) begin
					o_op.imm = {{(`CORE_XLEN-16){1'b0}}, imm};
				end else begin
					// lui reads no source
					o_op.imm = {imm, 16'h0000};
					o_op.ds = '0;
				end
			end
			`CORE_OP_OUT: begin
				o_op.valid = 1'b1;
				o_op.unit = core_pkg::unit_out;
				o_op.ope = i_word.imm_form.ope;
				o_op.ds = i_word.imm_form.ds;
			end
			default: o_op = '0;
		endcase
		// r0 as destination means no write
		o_op.writes_dd = (o_op.dd != '0);
	end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_unit (
	input logic clk,
	input logic rstn,
	input logic [2*`CORE_XLEN-1:0] i_rdata,
	input logic i_stall,
	output logic [`CORE_PCW-2:0] o_addr,
	output core_pkg::instr_u o_word0,
	output core_pkg::instr_u o_word1,
	output logic [1:0] o_word_vld
);

	logic [`CORE_PCW-1:0] pc;
	logic rd_vld;
	logic stall_q;
	logic [1:0] skid_vld;
	core_pkg::instr_u skid0;
	core_pkg::instr_u skid1;

	// word pc, two words per bundle
	assign o_addr = pc[`CORE_PCW-1:1];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			rd_vld <= 1'b0;
			stall_q <= 1'b0;
			skid_vld <= 2'b00;
		end else begin
			if (!i_stall) begin
				pc <= pc + `CORE_PCW'(2);
			end
			// no data back yet in the first cycle
			rd_vld <= 1'b1;
			stall_q <= i_stall;
			if (i_stall && !stall_q) begin
				skid_vld <= {2{rd_vld}};
			end
		end
	end

	// bundle that arrived on the first stall cycle
	always_ff @(posedge clk) begin
		if (i_stall && !stall_q) begin
			skid0 <= i_rdata[2*`CORE_XLEN-1:`CORE_XLEN];
			skid1 <= i_rdata[`CORE_XLEN-1:0];
		end
	end

	// replay skid contents once the stall lifts
	assign o_word0 = stall_q ? skid0 : i_rdata[2*`CORE_XLEN-1:`CORE_XLEN];
	assign o_word1 = stall_q ? skid1 : i_rdata[`CORE_XLEN-1:0];
	assign o_word_vld = stall_q ? skid_vld : {2{rd_vld}};

endmodule

// File: core_pkg.sv
package core_pkg;

`include "core_params.svh"

	// register form: ope dd ds dt shamt fn
	typedef struct packed {
		logic [`CORE_OPW-1:0] ope;
		logic [`CORE_RADDR-1:0] dd;
		logic [`CORE_RADDR-1:0] ds;
		logic [`CORE_RADDR-1:0] dt;
		logic [`CORE_RADDR-1:0] shamt;
		logic [5:0] fn;
	} reg_form_t;

	// immediate form: ope dd ds imm
	typedef struct packed {
		logic [`CORE_OPW-1:0] ope;
		logic [`CORE_RADDR-1:0] dd;
		logic [`CORE_RADDR-1:0] ds;
		logic [15:0] imm;
	} imm_form_t;

	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} instr_u;

	typedef enum logic [1:0] {
		unit_none = 2'd0,
		unit_alu = 2'd1,
		unit_out = 2'd2
	} unit_e;

	typedef struct packed {
		logic valid;
		unit_e unit;
		logic [`CORE_OPW-1:0] ope;
		logic [5:0] fn;
		logic [`CORE_RADDR-1:0] ds;
		logic [`CORE_RADDR-1:0] dt;
		logic uses_dt;
		logic [`CORE_RADDR-1:0] dd;
		logic writes_dd;
		logic [`CORE_XLEN-1:0] imm;
		logic [`CORE_RADDR-1:0] shamt;
	} dec_op_t;

	typedef struct packed {
		logic en;
		logic [`CORE_RADDR-1:0] addr;
		logic [`CORE_XLEN-1:0] data;
	} wb_t;

endpackage

// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN 32
`define CORE_NREG 32
`define CORE_RADDR 5
`define CORE_PCW 14
`define CORE_OPW 6
`define CORE_WIN 3

`define CORE_OP_NOP 6'h00
`define CORE_OP_REG 6'h01
`define CORE_OP_ADDI 6'h08
`define CORE_OP_ORI 6'h0d
`define CORE_OP_LUI 6'h0f
`define CORE_OP_OUT 6'h10

`define CORE_FN_ADD 6'h20
`define CORE_FN_SUB 6'h22
`define CORE_FN_AND 6'h24
`define CORE_FN_OR 6'h25
`define CORE_FN_XOR 6'h26
`define CORE_FN_SLL 6'h00

`endif
